/* files.f */
source/spi_pkg.sv
source/wb_arbiter.sv
source/spi_master_ctrl.sv
source/spi_shift_reg.sv
source/spi_master.sv
source/spi_slave.sv
source/spi_subsystem.sv
verif/tb_clk_gen.sv
verif/spi_subsystem_chk.sv
verif/spi_subsystem_tb.sv

/* Makefile */
TOP = spi_subsystem_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o sim

run: build
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "^Test completed successfully$$"

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* verif/spi_subsystem_tb.sv */
`timescale 1ns/1ps

module spi_subsystem_tb;

    localparam int W = spi_pkg::DATA_W;
    localparam int SCK_HALF = 4;
    localparam int N_ENTRIES = 9;
    localparam int TIMEOUT = N_ENTRIES * (16 * SCK_HALF + 20) + 200;

    // Entry kinds
    localparam int SINGLE = 0;
    localparam int CONTEND = 1;
    localparam int OVERLAP = 2;

    logic clk, rst;
    logic wb0_cyc, wb0_stb, wb0_we, wb0_ack;
    logic wb1_cyc, wb1_stb, wb1_we, wb1_ack;
    logic [W-1:0] wb0_dat_w, wb0_dat_r, wb1_dat_w, wb1_dat_r;
    logic m_ss, m_sck, m_mosi, s_miso, s_rdy;
    logic [W-1:0] s_wd, s_rd;

    // Stimulus table, the last four entries are drawn at random
    int kind [N_ENTRIES] = '{SINGLE, CONTEND, SINGLE, CONTEND, OVERLAP,
                             SINGLE, SINGLE, SINGLE, SINGLE};
    int port [N_ENTRIES] = '{0, 0, 1, 0, 1, 0, 0, 0, 0};
    logic [W-1:0] tx [N_ENTRIES] = '{8'ha5, 8'h3c, 8'h81, 8'h5a, 8'hc3,
                                     8'h00, 8'h00, 8'h00, 8'h00};
    logic [W-1:0] sb [N_ENTRIES] = '{8'h5e, 8'h0f, 8'h7e, 8'hf0, 8'h96,
                                     8'h00, 8'h00, 8'h00, 8'h00};

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    logic [W-1:0] captures [$];
    logic [7:0] sck_edges = 8'd0;
    logic sck_prev = 1'b0;
    logic ss_prev = 1'b1;

    tb_clk_gen clk_gen (.clk(clk), .rst(rst));

    // SPI pins looped back from master to slave
    spi_subsystem #(.sck_half_clks(SCK_HALF)) dut (
        .s_ss(m_ss), .s_sck(m_sck), .s_mosi(m_mosi), .m_miso(s_miso), .*
    );

    task automatic compare_byte(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic expect_capture(input logic [W-1:0] exp);
        assert (captures.size() > 0) else begin
            errors++;
            $display("No s_rdy pulse seen for a transfer of %h at %0t", exp, $time);
        end
        if (captures.size() > 0) begin
            compare_byte("s_rd", captures.pop_front(), exp);
        end
    endtask

    task automatic drive_port(input int p, input logic on, input logic we,
                              input logic [W-1:0] d);
        if (p == 0) begin
            wb0_cyc <= on;
            wb0_stb <= on;
            wb0_we <= we;
            wb0_dat_w <= d;
        end else begin
            wb1_cyc <= on;
            wb1_stb <= on;
            wb1_we <= we;
            wb1_dat_w <= d;
        end
    endtask

    // One Wishbone classic cycle, held until ack
    task automatic wb_access(input int p, input logic we, input logic [W-1:0] wdat,
                             output logic [W-1:0] rdat);
        @(posedge clk);
        drive_port(p, 1'b1, we, wdat);
        do @(negedge clk); while (!(p == 0 ? wb0_ack : wb1_ack));
        rdat = (p == 0) ? wb0_dat_r : wb1_dat_r;
        @(posedge clk);
        drive_port(p, 1'b0, 1'b0, 8'h00);
    endtask

    // Slave captures and sck edges per select window
    always @(negedge clk) begin
        if (s_rdy) begin
            captures.push_back(s_rd);
        end
        if (!m_ss && ss_prev) begin
            sck_edges = 8'd0;
        end
        if (m_sck && !sck_prev && !m_ss) begin
            sck_edges = sck_edges + 8'd1;
        end
        if (m_ss && !ss_prev) begin
            compare_byte("m_sck rises", sck_edges, 8'd8);
        end
        sck_prev = m_sck;
        ss_prev = m_ss;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Timeout after %0d cycles, a transfer never finished", cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        logic [W-1:0] rdat, rdat0, rdat1;
        int first, last_port, wr_cycle, rd_cycle, assert_fails;
        drive_port(0, 1'b0, 1'b0, 8'h00);
        drive_port(1, 1'b0, 1'b0, 8'h00);
        s_wd <= 8'h00;
        last_port = 0;
        wr_cycle = 0;
        rd_cycle = 0;
        void'($urandom(32'hde66_4759));
        for (int i = N_ENTRIES - 4; i < N_ENTRIES; i++) begin
            port[i] = $urandom_range(spi_pkg::N_HOSTS - 1, 0);
            tx[i] = W'($urandom);
            sb[i] = W'($urandom);
        end
        @(negedge rst);
        repeat (2) @(negedge clk);
        // Idle state, packed as m_ss m_sck s_rdy wb0_ack wb1_ack
        compare_byte("m_ss m_sck s_rdy wb0_ack wb1_ack",
                     {3'b000, m_ss, m_sck, s_rdy, wb0_ack, wb1_ack}, 8'h10);
        for (int i = 0; i < N_ENTRIES; i++) begin
            @(posedge clk);
            s_wd <= sb[i];
            case (kind[i])
                SINGLE: begin
                    wb_access(port[i], 1'b1, tx[i], rdat);
                    expect_capture(tx[i]);
                    wb_access(port[i], 1'b0, 8'h00, rdat);
                    compare_byte("wb_dat_r", rdat, sb[i]);
                    last_port = port[i];
                end
                CONTEND: begin
                    // Port not served last goes first, port 1 sends the inverted byte
                    first = 1 - last_port;
                    fork
                        wb_access(0, 1'b1, tx[i], rdat0);
                        wb_access(1, 1'b1, ~tx[i], rdat1);
                    join
                    expect_capture(first == 0 ? tx[i] : ~tx[i]);
                    expect_capture(first == 0 ? ~tx[i] : tx[i]);
                    last_port = 1 - first;
                end
                OVERLAP: begin
                    fork
                        begin
                            wb_access(port[i], 1'b1, tx[i], rdat0);
                            wr_cycle = cycles;
                        end
                        begin
                            do @(negedge clk); while (m_ss);
                            wb_access(1 - port[i], 1'b0, 8'h00, rdat1);
                            rd_cycle = cycles;
                        end
                    join
                    expect_capture(tx[i]);
                    compare_byte("wb_dat_r", rdat1, sb[i]);
                    assert (rd_cycle > wr_cycle) else begin
                        errors++;
                        $display("Read on port %0d ended before the write it overlapped",
                                 1 - port[i]);
                    end
                    last_port = 1 - port[i];
                end
                default: ;
            endcase
        end
        repeat (4) @(negedge clk);
        assert (captures.size() == 0) else begin
            errors++;
            $display("Slave pulsed rdy %0d more times than expected", captures.size());
        end
        assert_fails = dut.u_master.u_chk.fails + dut.u_slave.u_chk.fails;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verif/spi_subsystem_chk.sv */
`timescale 1ns/1ps

module spi_subsystem_chk (
    input logic clk,
    input logic rst,
    input logic stb,
    input logic ack,
    input logic ss,
    input logic sck,
    input logic start,
    input logic done,
    input logic rdy
);

    int fails = 0;
    logic in_xfer;

    // Open from the start of a transfer up to its done pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_xfer <= 1'b0;
        end else if (start) begin
            in_xfer <= 1'b1;
        end else if (done) begin
            in_xfer <= 1'b0;
        end
    end

    ack_needs_stb: assert property (@(posedge clk) disable iff (rst) ack |-> stb)
        else begin
            $error("ack high without stb");
            fails++;
        end

    // Mode 0, sck idles low
    sck_idle_low: assert property (@(posedge clk) disable iff (rst) ss |-> !sck)
        else begin
            $error("sck high while ss is high");
            fails++;
        end

    rdy_one_cycle: assert property (@(posedge clk) disable iff (rst) rdy |=> !rdy)
        else begin
            $error("rdy longer than one cycle");
            fails++;
        end

    ss_held_low: assert property (@(posedge clk) disable iff (rst) in_xfer |-> !ss)
        else begin
            $error("ss rose before done");
            fails++;
        end

endmodule

bind spi_master spi_subsystem_chk u_chk (
    .clk(clk), .rst(rst), .stb(stb), .ack(ack), .ss(ss), .sck(sck),
    .start(start), .done(done), .rdy(1'b0)
);

bind spi_slave spi_subsystem_chk u_chk (
    .clk(clk), .rst(rst), .stb(1'b0), .ack(1'b0), .ss(ss), .sck(sck),
    .start(1'b0), .done(1'b0), .rdy(rdy)
);

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released on a rising edge, after the flops have seen it
    initial begin
        rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* source/spi_subsystem.sv */
`timescale 1ns/1ps

module spi_subsystem #(
    parameter int sck_half_clks = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wb0_cyc,
    input  logic                       wb0_stb,
    input  logic                       wb0_we,
    input  logic [spi_pkg::DATA_W-1:0] wb0_dat_w,
    output logic [spi_pkg::DATA_W-1:0] wb0_dat_r,
    output logic                       wb0_ack,
    input  logic                       wb1_cyc,
    input  logic                       wb1_stb,
    input  logic                       wb1_we,
    input  logic [spi_pkg::DATA_W-1:0] wb1_dat_w,
    output logic [spi_pkg::DATA_W-1:0] wb1_dat_r,
    output logic                       wb1_ack,
    output logic                       m_ss,
    output logic                       m_sck,
    output logic                       m_mosi,
    input  logic                       m_miso,
    input  logic                       s_ss,
    input  logic                       s_sck,
    input  logic                       s_mosi,
    input  logic [spi_pkg::DATA_W-1:0] s_wd,
    output logic                       s_miso,
    output logic [spi_pkg::DATA_W-1:0] s_rd,
    output logic                       s_rdy
);

    // Shared Wishbone target side
    logic m_cyc, m_stb, m_we, m_ack;
    logic [spi_pkg::DATA_W-1:0] m_dat_w, m_dat_r;

    wb_arbiter u_arb (
        .clk(clk), .rst(rst),
        .wb0_cyc(wb0_cyc), .wb0_stb(wb0_stb), .wb0_we(wb0_we),
        .wb0_dat_w(wb0_dat_w), .wb0_dat_r(wb0_dat_r), .wb0_ack(wb0_ack),
        .wb1_cyc(wb1_cyc), .wb1_stb(wb1_stb), .wb1_we(wb1_we),
        .wb1_dat_w(wb1_dat_w), .wb1_dat_r(wb1_dat_r), .wb1_ack(wb1_ack),
        .m_cyc(m_cyc), .m_stb(m_stb), .m_we(m_we),
        .m_dat_w(m_dat_w), .m_dat_r(m_dat_r), .m_ack(m_ack)
    );

    spi_master #(.sck_half_clks(sck_half_clks)) u_master (
        .clk(clk), .rst(rst), .cyc(m_cyc), .stb(m_stb), .we(m_we),
        .dat_w(m_dat_w), .dat_r(m_dat_r), .ack(m_ack),
        .ss(m_ss), .sck(m_sck), .mosi(m_mosi), .miso(m_miso)
    );

    // Slave pins come back in through the testbench loopback
    spi_slave u_slave (
        .clk(clk), .rst(rst), .ss(s_ss), .sck(s_sck), .mosi(s_mosi),
        .wd(s_wd), .miso(s_miso), .rd(s_rd), .rdy(s_rdy)
    );

endmodule

/* source/spi_slave.sv */
`timescale 1ns/1ps

module spi_slave (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       ss,
    input  logic                       sck,
    input  logic                       mosi,
    input  logic [spi_pkg::DATA_W-1:0] wd,
    output logic                       miso,
    output logic [spi_pkg::DATA_W-1:0] rd,
    output logic                       rdy
);

    localparam int CNT_W = $clog2(spi_pkg::DATA_W);

    logic ss_meta, ss_sync, ss_prev;
    logic sck_meta, sck_sync, sck_prev;
    logic mosi_meta, mosi_sync;
    logic ss_fall, sample, shift, last_bit, sout;
    logic [CNT_W-1:0] count;
    logic [spi_pkg::DATA_W-1:0] pdata;

    // Two flops per pin, plus one history flop for edge detection
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {ss_meta, ss_sync, ss_prev} <= 3'b111;
            {sck_meta, sck_sync, sck_prev} <= 3'b000;
            {mosi_meta, mosi_sync} <= 2'b00;
        end else begin
            {ss_meta, ss_sync, ss_prev} <= {ss, ss_meta, ss_sync};
            {sck_meta, sck_sync, sck_prev} <= {sck, sck_meta, sck_sync};
            {mosi_meta, mosi_sync} <= {mosi, mosi_meta};
        end
    end

    assign ss_fall  = ss_prev && !ss_sync;
    assign sample   = !ss_sync && sck_sync && !sck_prev;
    assign shift    = !ss_sync && !sck_sync && sck_prev;
    assign last_bit = (count == CNT_W'(spi_pkg::DATA_W - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
            rdy   <= 1'b0;
        end else begin
            rdy <= sample && last_bit;
            if (ss_sync) begin
                count <= '0;
            end else if (sample) begin
                count <= last_bit ? '0 : count + 1'b1;
            end
        end
    end

    // The 8th bit is still in flight, so take it straight from mosi
    always_ff @(posedge clk) begin
        if (sample && last_bit) begin
            rd <= {pdata[spi_pkg::DATA_W-2:0], mosi_sync};
        end
    end

    assign miso = ss_sync ? 1'b0 : sout;

    spi_shift_reg u_sr (
        .clk(clk), .rst(rst), .load(ss_fall), .load_data(wd), .sample(sample),
        .shift(shift), .sin(mosi_sync), .sout(sout), .pdata(pdata)
    );

endmodule

/* source/spi_master.sv */
`timescale 1ns/1ps

module spi_master #(
    parameter int sck_half_clks = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [spi_pkg::DATA_W-1:0] dat_w,
    output logic [spi_pkg::DATA_W-1:0] dat_r,
    output logic                       ack,
    output logic                       ss,
    output logic                       sck,
    output logic                       mosi,
    input  logic                       miso
);

    logic busy;
    logic start;
    logic sample;
    logic shift;
    logic done;
    logic [spi_pkg::DATA_W-1:0] pdata;
    logic [spi_pkg::DATA_W-1:0] rx_byte;

    // A write kicks off one transfer, its ack waits for done
    assign start = cyc && stb && we && !busy && !ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            ack  <= 1'b0;
        end else begin
            if (start) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
            ack <= done || (cyc && stb && !we && !ack);
        end
    end

    // Last byte received, returned on reads
    always_ff @(posedge clk) begin
        if (done) begin
            rx_byte <= pdata;
        end
    end

    assign dat_r = rx_byte;

    spi_master_ctrl #(.sck_half_clks(sck_half_clks)) u_ctrl (
        .clk(clk), .rst(rst), .start(start), .ss(ss), .sck(sck),
        .sample(sample), .shift(shift), .done(done)
    );

    spi_shift_reg u_sr (
        .clk(clk), .rst(rst), .load(start), .load_data(dat_w), .sample(sample),
        .shift(shift), .sin(miso), .sout(mosi), .pdata(pdata)
    );

endmodule

/* source/spi_shift_reg.sv */
`timescale 1ns/1ps

module spi_shift_reg (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load,
    input  logic [spi_pkg::DATA_W-1:0] load_data,
    input  logic                       sample,
    input  logic                       shift,
    input  logic                       sin,
    output logic                       sout,
    output logic [spi_pkg::DATA_W-1:0] pdata
);

    logic [spi_pkg::DATA_W-1:0] sr;
    logic captured;

    // Sampling and shifting happen on opposite sck edges
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sr       <= '0;
            captured <= 1'b0;
        end else begin
            if (sample) begin
                captured <= sin;
            end
            if (load) begin
                sr <= load_data;
            end else if (shift) begin
                sr <= {sr[spi_pkg::DATA_W-2:0], captured};
            end
        end
    end

    // MSB first on the wire
    assign sout  = sr[spi_pkg::DATA_W-1];
    assign pdata = sr;

endmodule

/* source/spi_master_ctrl.sv */
`timescale 1ns/1ps

module spi_master_ctrl #(
    parameter int sck_half_clks = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic ss,
    output logic sck,
    output logic sample,
    output logic shift,
    output logic done
);

    localparam int DIV_W = $clog2(sck_half_clks);
    localparam int CNT_W = $clog2(spi_pkg::DATA_W + 1);

    typedef enum logic [1:0] {
        IDLE,
        SELECT,
        GEN_CLK
    } ctrl_state_e;

    ctrl_state_e state;
    logic [DIV_W-1:0] div;
    logic [CNT_W-1:0] edges;
    logic tick;
    logic last_edge;

    // End of a half-period
    assign tick      = (div == DIV_W'(sck_half_clks - 1));
    assign last_edge = (edges == CNT_W'(spi_pkg::DATA_W));

    // Strobes line up with the clk edge that moves sck
    assign sample = tick && ((state == SELECT) || (state == GEN_CLK && !sck && !last_edge));
    assign shift  = tick && (state == GEN_CLK) && sck;
    assign done   = tick && (state == GEN_CLK) && !sck && last_edge;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            div   <= '0;
            edges <= '0;
            ss    <= 1'b1;
            sck   <= 1'b0;
        end else begin
            div <= tick ? '0 : div + 1'b1;
            case (state)
                IDLE: begin
                    div <= '0;
                    if (start) begin
                        state <= SELECT;
                        edges <= '0;
                        ss    <= 1'b0;
                    end
                end
                // ss low for one half-period before the first rising edge
                SELECT: if (tick) begin
                    state <= GEN_CLK;
                    sck   <= 1'b1;
                    edges <= CNT_W'(1);
                end
                GEN_CLK: if (tick) begin
                    if (sck) begin
                        sck <= 1'b0;
                    end else if (last_edge) begin
                        state <= IDLE;
                        ss    <= 1'b1;
                    end else begin
                        sck   <= 1'b1;
                        edges <= edges + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* source/wb_arbiter.sv */
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wb0_cyc,
    input  logic                       wb0_stb,
    input  logic                       wb0_we,
    input  logic [spi_pkg::DATA_W-1:0] wb0_dat_w,
    output logic [spi_pkg::DATA_W-1:0] wb0_dat_r,
    output logic                       wb0_ack,
    input  logic                       wb1_cyc,
    input  logic                       wb1_stb,
    input  logic                       wb1_we,
    input  logic [spi_pkg::DATA_W-1:0] wb1_dat_w,
    output logic [spi_pkg::DATA_W-1:0] wb1_dat_r,
    output logic                       wb1_ack,
    output logic                       m_cyc,
    output logic                       m_stb,
    output logic                       m_we,
    output logic [spi_pkg::DATA_W-1:0] m_dat_w,
    input  logic [spi_pkg::DATA_W-1:0] m_dat_r,
    input  logic                       m_ack
);

    spi_pkg::arb_state_e state;
    logic [$clog2(spi_pkg::N_HOSTS)-1:0] last_served;

    // Grant is held for the whole cycle of the winning port
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= spi_pkg::IDLE;
            last_served <= '1;
        end else begin
            case (state)
                spi_pkg::IDLE: begin
                    // On contention the port not served last goes first
                    if (wb0_cyc && (!wb1_cyc || last_served != '0)) begin
                        state       <= spi_pkg::GRANT0;
                        last_served <= '0;
                    end else if (wb1_cyc) begin
                        state       <= spi_pkg::GRANT1;
                        last_served <= '1;
                    end
                end
                spi_pkg::GRANT0: if (!wb0_cyc) state <= spi_pkg::IDLE;
                spi_pkg::GRANT1: if (!wb1_cyc) state <= spi_pkg::IDLE;
                default:         state <= spi_pkg::IDLE;
            endcase
        end
    end

    // Read data is shared, only the ack is steered
    assign wb0_dat_r = m_dat_r;
    assign wb1_dat_r = m_dat_r;
    assign wb0_ack   = (state == spi_pkg::GRANT0) && m_ack;
    assign wb1_ack   = (state == spi_pkg::GRANT1) && m_ack;

    always_comb begin
        m_cyc   = 1'b0;
        m_stb   = 1'b0;
        m_we    = 1'b0;
        m_dat_w = '0;
        case (state)
            spi_pkg::GRANT0: begin
                m_cyc   = wb0_cyc;
                m_stb   = wb0_stb;
                m_we    = wb0_we;
                m_dat_w = wb0_dat_w;
            end
            spi_pkg::GRANT1: begin
                m_cyc   = wb1_cyc;
                m_stb   = wb1_stb;
                m_we    = wb1_we;
                m_dat_w = wb1_dat_w;
            end
            default: ;
        endcase
    end

endmodule

/* source/spi_pkg.sv */
package spi_pkg;

    // Width of one SPI transfer
    localparam int DATA_W = 8;

    // Wishbone host ports sharing the master
    localparam int N_HOSTS = 2;

    // Arbiter grant state
    typedef enum logic [1:0] {
        IDLE,
        GRANT0,
        GRANT1
    } arb_state_e;

endpackage
